/* logic/phxIsaPkg.sv */
package phxIsaPkg;

	// ====================
	// Opcodes and function codes
	// ====================

	typedef enum logic [5:0] {
		R2 = 6'd0,
		ADDI = 6'd4, SUBFI = 6'd5, ANDI = 6'd8, ORI = 6'd9, XORI = 6'd10, CMPI = 6'd11,
		LDB = 6'd16, LDBU = 6'd17, LDW = 6'd18, LDWU = 6'd19, LDT = 6'd20,
		STB = 6'd24, STW = 6'd25, STT = 6'd26,
		Bcc = 6'd28, CALL = 6'd32, BSR = 6'd33, RET = 6'd34,
		CSR = 6'd36, FMA = 6'd40,
		NOP = 6'd61, BRK = 6'd62, PFX = 6'd63
	} Opcode;

	// Function codes of the R2 major opcode
	typedef enum logic [5:0] {
		R1 = 6'd1,
		ADD = 6'd4, SUB = 6'd5, AND = 6'd8, OR = 6'd9, XOR = 6'd10,
		SLL = 6'd12, SRL = 6'd13, SRA = 6'd14,
		LDBX = 6'd16, LDBUX = 6'd17, LDWX = 6'd18, LDWUX = 6'd19, LDTX = 6'd20,
		STBX = 6'd24, STWX = 6'd25, STTX = 6'd26
	} R2Func;

	// Under R1 the Rb field carries a sub-operation
	localparam logic [6:0] RTI = 7'd1;
	localparam logic [6:0] REX = 7'd2;

	// ====================
	// Registers
	// ====================

	typedef struct packed {
		logic vec;
		logic [5:0] num;
	} RegSpec;

	localparam logic [6:0] RegSp = 7'd31;
	// Banked stack pointers live at 52 to 55, one past this base per mode
	localparam logic [6:0] SpBankBase = 7'd51;
	localparam logic [6:0] LinkBase = 7'd48;

	// ====================
	// Instruction formats
	// ====================

	typedef union packed {
		struct packed {logic [33:0] body; Opcode opcode;} any;
		struct packed {
			R2Func func;
			logic [2:0] pad;
			logic [2:0] Rm;
			logic m;
			RegSpec Rb;
			RegSpec Ra;
			RegSpec Rt;
			Opcode opcode;
		} r2;
		struct packed {logic [15:0] imm; logic [3:0] pad; RegSpec Ra; RegSpec Rt; Opcode opcode;} ri;
		struct packed {logic [15:0] disp; logic [3:0] pad; RegSpec Ra; RegSpec Rt; Opcode opcode;} ls;
		struct packed {logic [15:0] disp; logic [3:0] pad; RegSpec Ra; RegSpec Rt; Opcode opcode;} br;
		struct packed {logic [31:0] target; logic [1:0] Rt; Opcode opcode;} call;
		struct packed {
			logic [5:0] pad;
			RegSpec Rc;
			RegSpec Rb;
			RegSpec Ra;
			RegSpec Rt;
			Opcode opcode;
		} f3;
		struct packed {logic [15:0] imm; logic [1:0] func; logic [15:0] pad; Opcode opcode;} csr;
		struct packed {logic [15:0] imm; logic [17:0] pad; Opcode opcode;} pfx;
	} Instruction;

endpackage

/* logic/phxPipePkg.sv */
package phxPipePkg;

	// ====================
	// Memory and mode codes
	// ====================

	typedef enum logic [1:0] {
		MemByte = 2'd0,
		MemWyde = 2'd1,
		MemTetra = 2'd2,
		MemVect = 2'd3
	} MemSize;

	// Selects which stack pointer stands in for register 31
	typedef logic [2:0] SpSel;

	localparam SpSel ModeUser = 3'd0;
	localparam SpSel ModeBreak = 3'd4;
	localparam SpSel SpBankFirst = 3'd1;
	localparam SpSel SpBankLast = 3'd4;

	// ====================
	// Pipeline bundles
	// ====================

	typedef struct packed {
		logic v;
		phxIsaPkg::Instruction insn;
		logic pfxValid;
		logic [15:0] pfxImm;
	} FetchBundle;

	typedef struct packed {
		logic v;
		phxIsaPkg::RegSpec Ra;
		phxIsaPkg::RegSpec Rb;
		phxIsaPkg::RegSpec Rc;
		phxIsaPkg::RegSpec Rt;
		logic hasRa;
		logic hasRb;
		logic hasRc;
		logic hasRt;
		logic rfwr;
		logic vrfwr;
		logic [31:0] imm;
		logic load;
		logic loadu;
		logic loadr;
		logic loadn;
		logic store;
		logic storer;
		logic storen;
		MemSize memsz;
		logic br;
		logic cjb;
		logic csr;
		logic csrrd;
		logic csrrw;
		logic csrrc;
		logic csrrs;
		logic brk;
		logic rti;
		logic rex;
		logic multicycle;
		logic isVector;
		logic needSteps;
	} DecodeBus;

endpackage

/* logic/phxPrefixMerge.sv */
module phxPrefixMerge (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input phxIsaPkg::Instruction insnWord,
	output phxPipePkg::FetchBundle bundle
);

	logic isPfx;
	logic pfxPending;
	logic [15:0] pfxHeld;
	logic outV;
	phxIsaPkg::Instruction outInsn;
	logic outPfxValid;
	logic [15:0] outPfxImm;

	assign isPfx = insnWord.any.opcode == phxIsaPkg::PFX;

	// A prefix arms the pending flag and any other strobed word disarms it
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pfxPending <= 1'b0;
			outV <= 1'b0;
		end else begin
			outV <= insnValid && !isPfx;
			if (insnValid)
				pfxPending <= isPfx;
		end
	end

	// Latest prefix wins, so a second prefix simply overwrites the held bits
	always_ff @(posedge clk) begin
		if (insnValid && isPfx)
			pfxHeld <= insnWord.pfx.imm;
		if (insnValid && !isPfx) begin
			outInsn <= insnWord;
			outPfxValid <= pfxPending;
			outPfxImm <= pfxHeld;
		end
	end

	always_comb begin
		bundle.v = outV;
		bundle.insn = outInsn;
		bundle.pfxValid = outPfxValid;
		bundle.pfxImm = outPfxImm;
	end

endmodule

/* logic/phxDecoder.sv */
module phxDecoder (
	input phxPipePkg::FetchBundle bundle,
	input phxPipePkg::SpSel spSel,
	output phxPipePkg::DecodeBus deco
);

	phxIsaPkg::Instruction insn;
	phxIsaPkg::Opcode op;
	phxIsaPkg::R2Func fn;
	phxIsaPkg::RegSpec rawRt;
	phxIsaPkg::RegSpec rawRc;
	logic aluR;
	logic aluI;
	logic idxLoad;
	logic idxStore;
	logic regLoad;
	logic regStore;
	logic isR1;
	logic isCall;
	logic writes;

	// Register 31 is swapped for the banked stack pointer of the current mode
	function automatic phxIsaPkg::RegSpec remapSp(
		input phxIsaPkg::RegSpec r,
		input phxPipePkg::SpSel sel
	);
		phxIsaPkg::RegSpec res;
		res = r;
		if (r == phxIsaPkg::RegSp && sel >= phxPipePkg::SpBankFirst
				&& sel <= phxPipePkg::SpBankLast)
			res = phxIsaPkg::RegSpec'(phxIsaPkg::SpBankBase + 7'(sel));
		return res;
	endfunction

	assign insn = bundle.insn;
	assign op = insn.any.opcode;
	assign fn = insn.r2.func;

	// ====================
	// Instruction classes
	// ====================

	assign aluR = op == phxIsaPkg::R2 && fn inside {phxIsaPkg::ADD, phxIsaPkg::SUB,
		phxIsaPkg::AND, phxIsaPkg::OR, phxIsaPkg::XOR, phxIsaPkg::SLL, phxIsaPkg::SRL,
		phxIsaPkg::SRA};
	assign idxLoad = op == phxIsaPkg::R2 && fn inside {phxIsaPkg::LDBX, phxIsaPkg::LDBUX,
		phxIsaPkg::LDWX, phxIsaPkg::LDWUX, phxIsaPkg::LDTX};
	assign idxStore = op == phxIsaPkg::R2
		&& fn inside {phxIsaPkg::STBX, phxIsaPkg::STWX, phxIsaPkg::STTX};
	assign isR1 = op == phxIsaPkg::R2 && fn == phxIsaPkg::R1;
	assign aluI = op inside {phxIsaPkg::ADDI, phxIsaPkg::SUBFI, phxIsaPkg::ANDI,
		phxIsaPkg::ORI, phxIsaPkg::XORI, phxIsaPkg::CMPI};
	assign regLoad = op inside {phxIsaPkg::LDB, phxIsaPkg::LDBU, phxIsaPkg::LDW,
		phxIsaPkg::LDWU, phxIsaPkg::LDT};
	assign regStore = op inside {phxIsaPkg::STB, phxIsaPkg::STW, phxIsaPkg::STT};
	assign isCall = op inside {phxIsaPkg::CALL, phxIsaPkg::BSR};

	// Classes that produce a result in a register file
	assign writes = aluR || idxLoad || aluI || regLoad || isCall || op == phxIsaPkg::FMA
		|| op == phxIsaPkg::CSR || op == phxIsaPkg::RET;

	// Branches and stores read their data operand from the Rt field
	assign rawRc = (op == phxIsaPkg::Bcc || regStore || idxStore) ? insn.r2.Rt : insn.f3.Rc;

	always_comb begin
		case (op)
		phxIsaPkg::R2:
			rawRt = (aluR || idxLoad || idxStore) ? insn.r2.Rt : '0;
		phxIsaPkg::ADDI, phxIsaPkg::SUBFI, phxIsaPkg::ANDI, phxIsaPkg::ORI,
		phxIsaPkg::XORI, phxIsaPkg::CMPI, phxIsaPkg::RET, phxIsaPkg::CSR:
			rawRt = insn.ri.Rt;
		phxIsaPkg::LDB, phxIsaPkg::LDBU, phxIsaPkg::LDW, phxIsaPkg::LDWU, phxIsaPkg::LDT,
		phxIsaPkg::STB, phxIsaPkg::STW, phxIsaPkg::STT:
			rawRt = insn.ls.Rt;
		phxIsaPkg::FMA:
			rawRt = insn.f3.Rt;
		phxIsaPkg::Bcc:
			rawRt = insn.br.Rt;
		// Link registers 49 to 51, zero means no link
		phxIsaPkg::CALL, phxIsaPkg::BSR:
			rawRt = (insn.call.Rt == 2'd0) ? '0
				: phxIsaPkg::RegSpec'(phxIsaPkg::LinkBase + 7'(insn.call.Rt));
		default:
			rawRt = '0;
		endcase
	end

	// ====================
	// Decode bus
	// ====================

	always_comb begin
		deco = '0;
		deco.v = bundle.v;

		deco.Ra = remapSp(insn.r2.Ra, spSel);
		deco.Rb = remapSp(insn.r2.Rb, spSel);
		deco.Rc = remapSp(rawRc, spSel);
		deco.Rt = remapSp(rawRt, spSel);
		deco.hasRa = op != phxIsaPkg::PFX && !isCall;
		deco.hasRb = (op == phxIsaPkg::R2 && !isR1) || op == phxIsaPkg::FMA;
		deco.hasRc = op == phxIsaPkg::FMA;
		deco.hasRt = op != phxIsaPkg::PFX;

		// Never write scalar register zero
		deco.vrfwr = writes && rawRt.vec;
		deco.rfwr = writes && !rawRt.vec && rawRt != '0;

		if (aluI || op == phxIsaPkg::RET || op == phxIsaPkg::CSR)
			deco.imm = {{16{insn.ri.imm[15]}}, insn.ri.imm};
		else if (regLoad || regStore)
			deco.imm = {{16{insn.ls.disp[15]}}, insn.ls.disp};
		else if (op == phxIsaPkg::Bcc)
			deco.imm = {{16{insn.br.disp[15]}}, insn.br.disp};
		else if (isCall)
			deco.imm = insn.call.target;
		if (bundle.pfxValid)
			deco.imm[31:16] = bundle.pfxImm;

		deco.loadr = regLoad;
		deco.loadn = idxLoad;
		deco.storer = regStore;
		deco.storen = idxStore;
		deco.load = regLoad || idxLoad;
		deco.store = regStore || idxStore;
		deco.loadu = op inside {phxIsaPkg::LDBU, phxIsaPkg::LDWU}
			|| (op == phxIsaPkg::R2 && fn inside {phxIsaPkg::LDBUX, phxIsaPkg::LDWUX});

		if (op inside {phxIsaPkg::LDB, phxIsaPkg::LDBU, phxIsaPkg::STB}
				|| (op == phxIsaPkg::R2
				&& fn inside {phxIsaPkg::LDBX, phxIsaPkg::LDBUX, phxIsaPkg::STBX}))
			deco.memsz = phxPipePkg::MemByte;
		else if (op inside {phxIsaPkg::LDW, phxIsaPkg::LDWU, phxIsaPkg::STW}
				|| (op == phxIsaPkg::R2
				&& fn inside {phxIsaPkg::LDWX, phxIsaPkg::LDWUX, phxIsaPkg::STWX}))
			deco.memsz = phxPipePkg::MemWyde;
		else
			deco.memsz = phxPipePkg::MemTetra;

		deco.isVector = (deco.hasRt && deco.Rt.vec) || (deco.hasRa && deco.Ra.vec)
			|| (deco.hasRb && deco.Rb.vec) || (deco.hasRc && deco.Rc.vec);

		// The index register only counts as a vector operand for indexed accesses
		if ((deco.hasRa && deco.Ra.vec) || ((idxLoad || idxStore) && deco.hasRb && deco.Rb.vec)
				|| (deco.hasRt && deco.Rt.vec))
			deco.memsz = phxPipePkg::MemVect;
		deco.needSteps = deco.memsz == phxPipePkg::MemVect
			&& !((regLoad || regStore) && !deco.Ra.vec);

		deco.br = op == phxIsaPkg::Bcc;
		deco.cjb = isCall;
		deco.csr = op == phxIsaPkg::CSR;
		deco.csrrd = deco.csr && insn.csr.func == 2'd0;
		deco.csrrw = deco.csr && insn.csr.func == 2'd1;
		deco.csrrc = deco.csr && insn.csr.func == 2'd2;
		deco.csrrs = deco.csr && insn.csr.func == 2'd3;

		deco.brk = op == phxIsaPkg::BRK;
		deco.rti = isR1 && insn.r2.Rb == phxIsaPkg::RTI;
		deco.rex = isR1 && insn.r2.Rb == phxIsaPkg::REX;
		deco.multicycle = op == phxIsaPkg::FMA;
	end

endmodule

/* logic/phxModeStack.sv */
module phxModeStack #(
	parameter int ModeDepth = 4
) (
	input logic clk,
	input logic rstN,
	input phxPipePkg::DecodeBus deco,
	output phxPipePkg::SpSel spSel
);

	localparam int CntW = $clog2(ModeDepth + 1);

	phxPipePkg::SpSel mode;
	phxPipePkg::SpSel stack [ModeDepth];
	logic [CntW-1:0] count;
	logic doPush;
	logic doPop;

	assign doPush = deco.v && deco.brk;
	assign doPop = deco.v && deco.rti;

	// A pop from an empty stack falls back to user mode
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mode <= phxPipePkg::ModeUser;
			count <= '0;
		end else if (doPush) begin
			mode <= phxPipePkg::ModeBreak;
			if (count != CntW'(ModeDepth))
				count <= count + 1'b1;
		end else if (doPop) begin
			mode <= (count != '0) ? stack[0] : phxPipePkg::ModeUser;
			if (count != '0)
				count <= count - 1'b1;
		end
	end

	// Entry 0 is the top, a push into a full stack drops the bottom entry
	always_ff @(posedge clk) begin
		if (doPush) begin
			stack[0] <= mode;
			for (int i = 1; i < ModeDepth; i++)
				stack[i] <= stack[i-1];
		end else if (doPop) begin
			for (int i = 0; i < ModeDepth - 1; i++)
				stack[i] <= stack[i+1];
		end
	end

	assign spSel = mode;

endmodule

/* logic/phxDecodeFront.sv */
module phxDecodeFront #(
	parameter int ModeDepth = 4
) (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input phxIsaPkg::Instruction insnWord,
	output phxPipePkg::DecodeBus deco
);

	phxPipePkg::FetchBundle bundle;
	phxPipePkg::SpSel spSel;

	phxPrefixMerge merge (
		.clk(clk),
		.rstN(rstN),
		.insnValid(insnValid),
		.insnWord(insnWord),
		.bundle(bundle)
	);

	phxDecoder decoder (
		.bundle(bundle),
		.spSel(spSel),
		.deco(deco)
	);

	// Mode follows decoded break and return one cycle behind decode
	phxModeStack #(
		.ModeDepth(ModeDepth)
	) modeStack (
		.clk(clk),
		.rstN(rstN),
		.deco(deco),
		.spSel(spSel)
	);

endmodule

/* sim/phxDecodeChecker.sv */
module phxDecodeChecker #(
	parameter int ModeDepth = 4,
	parameter int NumTests = 5
) (
	input logic clk,
	input logic rstN,
	input logic insnValid,
	input phxIsaPkg::Instruction insnWord,
	input phxPipePkg::DecodeBus deco,
	input int testIdx,
	output int errorCount,
	output int failedTests,
	output logic reportDone
);

	timeunit 1ns;
	timeprecision 100ps;

	logic pfxPending;
	logic [15:0] pfxBits;
	phxPipePkg::SpSel modeNow;
	phxPipePkg::SpSel modeSaved [$];
	logic awaiting;
	phxPipePkg::DecodeBus expected;
	int curTest = 0;
	int testChecks = 0;
	int testErrors = 0;
	int passedTests = 0;
	int totalChecks = 0;

	initial begin
		errorCount = 0;
		failedTests = 0;
		reportDone = 1'b0;
	end

	function automatic string testName(input int i);
		case (i)
		0: return "aluForms";
		1: return "loadStore";
		2: return "controlFlowCsr";
		3: return "modeStack";
		default: return "randomMix";
		endcase
	endfunction

	function automatic logic [31:0] signExt(input logic [15:0] x);
		return {{16{x[15]}}, x};
	endfunction

	// Register 31 names the stack pointer of the current mode, banks 52 to 55
	function automatic phxIsaPkg::RegSpec bankSp(
		input phxIsaPkg::RegSpec r,
		input phxPipePkg::SpSel mode
	);
		if (!r.vec && r.num == 6'd31 && mode >= 3'd1 && mode <= 3'd4)
			return phxIsaPkg::RegSpec'(7'd51 + 7'(mode));
		return r;
	endfunction

	// ====================
	// Reference decode
	// ====================

	function automatic phxPipePkg::DecodeBus modelDecode(
		input phxIsaPkg::Instruction w,
		input logic pfxOn,
		input logic [15:0] pfxHi,
		input phxPipePkg::SpSel mode
	);
		phxPipePkg::DecodeBus d;
		phxIsaPkg::RegSpec target;
		phxIsaPkg::RegSpec data;
		logic writesReg;
		logic indexed;
		logic plainMem;
		d = '0;
		d.v = 1'b1;
		d.hasRa = 1'b1;
		d.hasRt = 1'b1;
		d.memsz = phxPipePkg::MemTetra;
		target = '0;
		data = w.f3.Rc;
		writesReg = 1'b0;
		indexed = 1'b0;
		plainMem = 1'b0;
		case (w.any.opcode)
		phxIsaPkg::R2: begin
			d.hasRb = w.r2.func != phxIsaPkg::R1;
			case (w.r2.func)
			phxIsaPkg::ADD, phxIsaPkg::SUB, phxIsaPkg::AND, phxIsaPkg::OR, phxIsaPkg::XOR,
			phxIsaPkg::SLL, phxIsaPkg::SRL, phxIsaPkg::SRA: begin
				target = w.r2.Rt;
				writesReg = 1'b1;
			end
			phxIsaPkg::LDBX, phxIsaPkg::LDBUX, phxIsaPkg::LDWX, phxIsaPkg::LDWUX,
			phxIsaPkg::LDTX: begin
				target = w.r2.Rt;
				writesReg = 1'b1;
				indexed = 1'b1;
				d.load = 1'b1;
				d.loadn = 1'b1;
			end
			phxIsaPkg::STBX, phxIsaPkg::STWX, phxIsaPkg::STTX: begin
				target = w.r2.Rt;
				data = w.r2.Rt;
				indexed = 1'b1;
				d.store = 1'b1;
				d.storen = 1'b1;
			end
			phxIsaPkg::R1: begin
				d.rti = w.r2.Rb == 7'd1;
				d.rex = w.r2.Rb == 7'd2;
			end
			default: ;
			endcase
			case (w.r2.func)
			phxIsaPkg::LDBX, phxIsaPkg::LDBUX, phxIsaPkg::STBX:
				d.memsz = phxPipePkg::MemByte;
			phxIsaPkg::LDWX, phxIsaPkg::LDWUX, phxIsaPkg::STWX:
				d.memsz = phxPipePkg::MemWyde;
			default: ;
			endcase
			d.loadu = w.r2.func inside {phxIsaPkg::LDBUX, phxIsaPkg::LDWUX};
		end
		phxIsaPkg::ADDI, phxIsaPkg::SUBFI, phxIsaPkg::ANDI, phxIsaPkg::ORI, phxIsaPkg::XORI,
		phxIsaPkg::CMPI, phxIsaPkg::RET, phxIsaPkg::CSR: begin
			target = w.ri.Rt;
			writesReg = 1'b1;
			d.imm = signExt(w.ri.imm);
		end
		phxIsaPkg::LDB, phxIsaPkg::LDBU, phxIsaPkg::LDW, phxIsaPkg::LDWU, phxIsaPkg::LDT: begin
			target = w.ls.Rt;
			writesReg = 1'b1;
			plainMem = 1'b1;
			d.load = 1'b1;
			d.loadr = 1'b1;
			d.imm = signExt(w.ls.disp);
		end
		phxIsaPkg::STB, phxIsaPkg::STW, phxIsaPkg::STT: begin
			target = w.ls.Rt;
			data = w.ls.Rt;
			plainMem = 1'b1;
			d.store = 1'b1;
			d.storer = 1'b1;
			d.imm = signExt(w.ls.disp);
		end
		phxIsaPkg::Bcc: begin
			target = w.br.Rt;
			data = w.br.Rt;
			d.br = 1'b1;
			d.imm = signExt(w.br.disp);
		end
		phxIsaPkg::CALL, phxIsaPkg::BSR: begin
			d.hasRa = 1'b0;
			d.cjb = 1'b1;
			writesReg = 1'b1;
			d.imm = w.call.target;
			if (w.call.Rt != 2'd0)
				target = phxIsaPkg::RegSpec'(7'd48 + 7'(w.call.Rt));
		end
		phxIsaPkg::FMA: begin
			target = w.f3.Rt;
			writesReg = 1'b1;
			d.hasRb = 1'b1;
			d.hasRc = 1'b1;
			d.multicycle = 1'b1;
		end
		phxIsaPkg::BRK:
			d.brk = 1'b1;
		phxIsaPkg::PFX: begin
			d.hasRa = 1'b0;
			d.hasRt = 1'b0;
		end
		default: ;
		endcase

		// Width letters of the plain loads and stores
		case (w.any.opcode)
		phxIsaPkg::LDB, phxIsaPkg::LDBU, phxIsaPkg::STB:
			d.memsz = phxPipePkg::MemByte;
		phxIsaPkg::LDW, phxIsaPkg::LDWU, phxIsaPkg::STW:
			d.memsz = phxPipePkg::MemWyde;
		default: ;
		endcase
		if (w.any.opcode inside {phxIsaPkg::LDBU, phxIsaPkg::LDWU})
			d.loadu = 1'b1;

		if (w.any.opcode == phxIsaPkg::CSR) begin
			d.csr = 1'b1;
			d.csrrd = w.csr.func == 2'd0;
			d.csrrw = w.csr.func == 2'd1;
			d.csrrc = w.csr.func == 2'd2;
			d.csrrs = w.csr.func == 2'd3;
		end

		if (pfxOn)
			d.imm[31:16] = pfxHi;
		d.vrfwr = writesReg && target.vec;
		d.rfwr = writesReg && !target.vec && target.num != 6'd0;

		d.Ra = bankSp(w.r2.Ra, mode);
		d.Rb = bankSp(w.r2.Rb, mode);
		d.Rc = bankSp(data, mode);
		d.Rt = bankSp(target, mode);
		d.isVector = (d.hasRt && d.Rt.vec) || (d.hasRa && d.Ra.vec)
			|| (d.hasRb && d.Rb.vec) || (d.hasRc && d.Rc.vec);
		if ((d.hasRa && d.Ra.vec) || (indexed && d.Rb.vec) || (d.hasRt && d.Rt.vec))
			d.memsz = phxPipePkg::MemVect;
		// A scalar base without an index walks the vector in one step
		d.needSteps = d.memsz == phxPipePkg::MemVect && (d.Ra.vec || !plainMem);
		return d;
	endfunction

	// ====================
	// Model state and compare
	// ====================

	task automatic countError();
		testErrors++;
		errorCount++;
	endtask

	task automatic advanceMode(input phxPipePkg::DecodeBus d);
		if (d.brk) begin
			modeSaved.push_front(modeNow);
			if (modeSaved.size() > ModeDepth)
				void'(modeSaved.pop_back());
			modeNow = 3'd4;
		end else if (d.rti) begin
			if (modeSaved.size() > 0)
				modeNow = modeSaved.pop_front();
			else
				modeNow = 3'd0;
		end
	endtask

	task automatic checkOutput();
		if (awaiting && !deco.v) begin
			$display("error in test %s: no valid decode output after an instruction strobe",
				testName(curTest));
			countError();
		end else if (!awaiting && deco.v) begin
			$display("error in test %s: decode output went valid without an instruction strobe",
				testName(curTest));
			countError();
		end else if (awaiting) begin
			testChecks++;
			totalChecks++;
			if (deco !== expected) begin
				$display("mismatch in test %s: expected %h, actual %h",
					testName(curTest), expected, deco);
				countError();
			end
		end
	endtask

	task automatic takeWord(input phxIsaPkg::Instruction w);
		if (w.any.opcode == phxIsaPkg::PFX) begin
			pfxPending = 1'b1;
			pfxBits = w.pfx.imm;
		end else begin
			expected = modelDecode(w, pfxPending, pfxBits, modeNow);
			pfxPending = 1'b0;
			awaiting = 1'b1;
			advanceMode(expected);
		end
	endtask

	task automatic finishTest();
		if (testChecks == 0) begin
			$display("error in test %s: no decode outputs were checked", testName(curTest));
			countError();
		end
		if (testErrors == 0)
			passedTests++;
		else
			failedTests++;
		$display("test %0d %s: %0d checks, %0d errors", curTest, testName(curTest),
			testChecks, testErrors);
		curTest = testIdx;
		testChecks = 0;
		testErrors = 0;
		if (curTest >= NumTests) begin
			$display("%0d tests passed, %0d tests failed, %0d outputs checked, %0d errors",
				passedTests, failedTests, totalChecks, errorCount);
			reportDone = 1'b1;
		end
	endtask

	// Deco is read before the edge updates it, so it belongs to the previous strobe
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pfxPending = 1'b0;
			pfxBits = '0;
			modeNow = 3'd0;
			modeSaved.delete();
			awaiting = 1'b0;
		end else begin
			checkOutput();
			if (testIdx != curTest)
				finishTest();
			awaiting = 1'b0;
			if (insnValid)
				takeWord(insnWord);
		end
	end

endmodule

/* sim/phxDecodeFrontTb.sv */
module phxDecodeFrontTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ModeDepth = 4;
	localparam int NumTests = 5;
	localparam int WordsPerTest = 200;
	localparam int MaxGap = 3;
	// Every word takes at most MaxGap cycles and the rest covers reset and draining
	localparam int CycleLimit = NumTests * WordsPerTest * MaxGap + 100;

	logic clk;
	logic rstN;
	logic insnValid;
	phxIsaPkg::Instruction insnWord;
	phxPipePkg::DecodeBus deco;
	int testIdx;
	int errorCount;
	int failedTests;
	logic reportDone;
	integer seed;
	int cycles = 0;
	int gap;

	phxDecodeFront #(
		.ModeDepth(ModeDepth)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.insnValid(insnValid),
		.insnWord(insnWord),
		.deco(deco)
	);

	phxDecodeChecker #(
		.ModeDepth(ModeDepth),
		.NumTests(NumTests)
	) scoreboard (
		.clk(clk),
		.rstN(rstN),
		.insnValid(insnValid),
		.insnWord(insnWord),
		.deco(deco),
		.testIdx(testIdx),
		.errorCount(errorCount),
		.failedTests(failedTests),
		.reportDone(reportDone)
	);

	always #4 clk = ~clk;

	// ====================
	// Stimulus helpers
	// ====================

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic phxIsaPkg::R2Func aluFunc();
		case (pick(8))
		0: return phxIsaPkg::ADD;
		1: return phxIsaPkg::SUB;
		2: return phxIsaPkg::AND;
		3: return phxIsaPkg::OR;
		4: return phxIsaPkg::XOR;
		5: return phxIsaPkg::SLL;
		6: return phxIsaPkg::SRL;
		default: return phxIsaPkg::SRA;
		endcase
	endfunction

	function automatic phxIsaPkg::Opcode immOp();
		case (pick(6))
		0: return phxIsaPkg::ADDI;
		1: return phxIsaPkg::SUBFI;
		2: return phxIsaPkg::ANDI;
		3: return phxIsaPkg::ORI;
		4: return phxIsaPkg::XORI;
		default: return phxIsaPkg::CMPI;
		endcase
	endfunction

	function automatic phxIsaPkg::Opcode memOp();
		case (pick(8))
		0: return phxIsaPkg::LDB;
		1: return phxIsaPkg::LDBU;
		2: return phxIsaPkg::LDW;
		3: return phxIsaPkg::LDWU;
		4: return phxIsaPkg::LDT;
		5: return phxIsaPkg::STB;
		6: return phxIsaPkg::STW;
		default: return phxIsaPkg::STT;
		endcase
	endfunction

	function automatic phxIsaPkg::R2Func indexedFunc();
		case (pick(8))
		0: return phxIsaPkg::LDBX;
		1: return phxIsaPkg::LDBUX;
		2: return phxIsaPkg::LDWX;
		3: return phxIsaPkg::LDWUX;
		4: return phxIsaPkg::LDTX;
		5: return phxIsaPkg::STBX;
		6: return phxIsaPkg::STWX;
		default: return phxIsaPkg::STTX;
		endcase
	endfunction

	function automatic phxIsaPkg::Opcode flowOp();
		case (pick(6))
		0: return phxIsaPkg::Bcc;
		1: return phxIsaPkg::CALL;
		2: return phxIsaPkg::BSR;
		3: return phxIsaPkg::RET;
		4: return phxIsaPkg::CSR;
		default: return phxIsaPkg::FMA;
		endcase
	endfunction

	// Operand fields start out random and each test narrows the opcode
	function automatic phxIsaPkg::Instruction makeWord(input int t, input int n);
		phxIsaPkg::Instruction w;
		int k;
		w = phxIsaPkg::Instruction'({8'($random(seed)), 32'($random(seed))});
		k = pick(10);
		case (t)
		0: begin
			if (k < 2) begin
				w.any.opcode = phxIsaPkg::PFX;
			end else if (k < 6) begin
				w.r2.opcode = phxIsaPkg::R2;
				w.r2.func = aluFunc();
			end else begin
				w.ri.opcode = immOp();
			end
		end
		1: begin
			if (k < 5) begin
				w.ls.opcode = memOp();
			end else begin
				w.r2.opcode = phxIsaPkg::R2;
				w.r2.func = indexedFunc();
			end
		end
		2:
			w.any.opcode = flowOp();
		3: begin
			// Six breaks overflow the stack, then seven returns run it past empty
			// Breaks and returns read register 31 so each one shows the mode it sees
			if (n < 6 || (n >= 13 && k < 3)) begin
				w.any.opcode = phxIsaPkg::BRK;
				w.r2.Ra = 7'd31;
			end else if (n < 13 || k < 6) begin
				w.r2.opcode = phxIsaPkg::R2;
				w.r2.func = phxIsaPkg::R1;
				w.r2.Rb = phxIsaPkg::RegSpec'(phxIsaPkg::RTI);
				w.r2.Ra = 7'd31;
			end else begin
				case (pick(4))
				0: begin
					w.r2.opcode = phxIsaPkg::R2;
					w.r2.func = aluFunc();
				end
				1: w.any.opcode = phxIsaPkg::FMA;
				2: w.any.opcode = phxIsaPkg::STT;
				default: w.any.opcode = phxIsaPkg::Bcc;
				endcase
				if (pick(2) == 0)
					w.f3.Rt = 7'd31;
				if (pick(2) == 0)
					w.f3.Ra = 7'd31;
				if (pick(2) == 0)
					w.f3.Rb = 7'd31;
				if (pick(2) == 0)
					w.f3.Rc = 7'd31;
			end
		end
		default: begin
			if (k < 3) begin
				w.r2.Rt = '0;
			end else if (k == 3) begin
				w.any.opcode = phxIsaPkg::NOP;
			end else if (k == 4 || k == 5) begin
				w.r2.opcode = phxIsaPkg::R2;
				w.r2.func = phxIsaPkg::R1;
				w.r2.Rb = (k == 4) ? phxIsaPkg::RegSpec'(phxIsaPkg::REX)
					: phxIsaPkg::RegSpec'(phxIsaPkg::RTI);
			end else if (k == 6) begin
				w.any.opcode = phxIsaPkg::PFX;
			end
		end
		endcase
		return w;
	endfunction

	// ====================
	// Run control
	// ====================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", CycleLimit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		seed = 32'h129c;
		clk = 1'b0;
		rstN = 1'b0;
		insnValid = 1'b0;
		insnWord = '0;
		testIdx = 0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		for (int t = 0; t < NumTests; t++) begin
			@(posedge clk);
			testIdx <= t;
			for (int n = 0; n < WordsPerTest; n++) begin
				gap = 1 + pick(MaxGap);
				@(posedge clk);
				insnValid <= 1'b1;
				insnWord <= makeWord(t, n);
				repeat (gap - 1) begin
					@(posedge clk);
					insnValid <= 1'b0;
				end
			end
			// Let the last decode of the test reach the checker
			@(posedge clk);
			insnValid <= 1'b0;
			repeat (2) @(posedge clk);
		end
		@(posedge clk);
		testIdx <= NumTests;
		wait (reportDone === 1'b1);
		if (errorCount == 0 && failedTests == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* vlog.f */
logic/phxIsaPkg.sv
logic/phxPipePkg.sv
logic/phxPrefixMerge.sv
logic/phxDecoder.sv
logic/phxModeStack.sv
logic/phxDecodeFront.sv
sim/phxDecodeChecker.sv
sim/phxDecodeFrontTb.sv
